// File: src/cdb_macros.svh
`ifndef CDB_MACROS_SVH
`define CDB_MACROS_SVH

// execution slots behind the dispatcher
`define CDB_NUM_FU 4

// issue ports from the scheduler
`define CDB_ISSUE_WIDTH 3

// broadcast lanes on the result bus
`define CDB_WIDTH 2

// result queue entries per slot and starting credits per slot
`define CDB_QUEUE_DEPTH 2

`define CDB_DATA_WIDTH 32
`define CDB_TAG_WIDTH 6

// derived widths
`define CDB_FU_IDX_WIDTH $clog2(`CDB_NUM_FU)
`define CDB_CREDIT_WIDTH $clog2(`CDB_QUEUE_DEPTH + 1)
`define CDB_QPTR_WIDTH $clog2(`CDB_QUEUE_DEPTH)

`endif

// File: src/cdb_pkg.sv
`include "cdb_macros.svh"

package cdb_pkg;

    // operand and result value
    typedef logic [`CDB_DATA_WIDTH-1:0] data_t;

    // destination physical register
    typedef logic [`CDB_TAG_WIDTH-1:0] tag_t;

    // which execution slot
    typedef logic [`CDB_FU_IDX_WIDTH-1:0] fu_idx_t;

    // holds 0 up to the queue depth
    typedef logic [`CDB_CREDIT_WIDTH-1:0] credit_t;

    // integer ops handled by every slot
    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_SUB = 2'd1,
        OP_AND = 2'd2,
        OP_XOR = 2'd3
    } alu_op_e;

    // one issue port, slot chosen by the issuer
    typedef struct packed {
        logic    valid;
        fu_idx_t fu;
        alu_op_e op;
        data_t   src_a;
        data_t   src_b;
        tag_t    tag;
    } issue_packet_t;

    // dispatcher to slot, slot index already consumed
    typedef struct packed {
        logic    valid;
        alu_op_e op;
        data_t   src_a;
        data_t   src_b;
        tag_t    tag;
    } exec_packet_t;

    // queued result inside a slot
    typedef struct packed {
        tag_t  tag;
        data_t value;
    } fu_result_t;

    // one lane of the broadcast bus
    typedef struct packed {
        logic  valid;
        tag_t  tag;
        data_t value;
    } cdb_packet_t;

endpackage

// File: src/issue_dispatch.sv
`include "cdb_macros.svh"

module issue_dispatch (
    input  logic                                          clock,
    input  logic                                          reset,
    input  cdb_pkg::issue_packet_t [`CDB_ISSUE_WIDTH-1:0] issue,
    output logic                   [`CDB_ISSUE_WIDTH-1:0] issue_ready,
    input  logic                   [`CDB_NUM_FU-1:0]      credit_return,
    output cdb_pkg::exec_packet_t  [`CDB_NUM_FU-1:0]      exec
);

    // one counter per slot, mirrors free queue entries
    cdb_pkg::credit_t credits [`CDB_NUM_FU];

    // a lower valid port already aims at the same slot
    logic [`CDB_ISSUE_WIDTH-1:0] lower_hit;
    logic [`CDB_ISSUE_WIDTH-1:0] accept;

    // per slot winner of this cycle
    logic                 [`CDB_NUM_FU-1:0] take;
    cdb_pkg::exec_packet_t                  winner [`CDB_NUM_FU];

    // ready per port
    // lowest port wins a slot, the rest wait a cycle
    always_comb begin
        for (int p = 0; p < `CDB_ISSUE_WIDTH; p++) begin
            lower_hit[p] = 1'b0;
            for (int q = 0; q < p; q++) begin
                if (issue[q].valid && (issue[q].fu == issue[p].fu)) begin
                    lower_hit[p] = 1'b1;
                end
            end
            // needs a credit on its target slot
            issue_ready[p] = !lower_hit[p] && (credits[issue[p].fu] != '0);
            accept[p]      = issue[p].valid && issue_ready[p];
        end
    end

    // route accepted packets to slots
    // at most one accepted port per slot by construction
    always_comb begin
        for (int f = 0; f < `CDB_NUM_FU; f++) begin
            take[f]   = 1'b0;
            winner[f] = '0;
            for (int p = 0; p < `CDB_ISSUE_WIDTH; p++) begin
                if (accept[p] && (issue[p].fu == cdb_pkg::fu_idx_t'(f))) begin
                    take[f]         = 1'b1;
                    winner[f].valid = 1'b1;
                    winner[f].op    = issue[p].op;
                    winner[f].src_a = issue[p].src_a;
                    winner[f].src_b = issue[p].src_b;
                    winner[f].tag   = issue[p].tag;
                end
            end
        end
    end

    // credit bookkeeping
    // spend and return can land on the same edge
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int f = 0; f < `CDB_NUM_FU; f++) begin
                credits[f] <= cdb_pkg::credit_t'(`CDB_QUEUE_DEPTH);
            end
        end else begin
            for (int f = 0; f < `CDB_NUM_FU; f++) begin
                credits[f] <= credits[f]
                            - cdb_pkg::credit_t'(take[f])
                            + cdb_pkg::credit_t'(credit_return[f]);
            end
        end
    end

    // exec register toward the slots
    // valid lasts one cycle per accepted packet
    always_ff @(posedge clock) begin
        for (int f = 0; f < `CDB_NUM_FU; f++) begin
            if (reset) begin
                exec[f].valid <= 1'b0;
            end else if (take[f]) begin
                exec[f] <= winner[f];
            end else begin
                // payload held, only valid drops
                exec[f].valid <= 1'b0;
            end
        end
    end

endmodule

// File: src/fu_slot.sv
`include "cdb_macros.svh"

module fu_slot (
    input  logic                  clock,
    input  logic                  reset,
    input  cdb_pkg::exec_packet_t exec,
    input  logic                  pop,
    output cdb_pkg::fu_result_t   head,
    output logic                  head_valid
);

    // queue index
    typedef logic [`CDB_QPTR_WIDTH-1:0] qptr_t;

    // compute stage
    cdb_pkg::data_t      alu_value;
    cdb_pkg::fu_result_t stage_result;
    logic                stage_valid;

    // result queue
    cdb_pkg::fu_result_t queue_mem [`CDB_QUEUE_DEPTH];
    qptr_t               wr_ptr;
    qptr_t               rd_ptr;
    cdb_pkg::credit_t    count;
    logic                push;
    logic                do_pop;

    // circular advance
    // depth need not be a power of two
    function automatic qptr_t ptr_next(input qptr_t ptr);
        if (ptr == qptr_t'(`CDB_QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + qptr_t'(1);
    endfunction

    // integer op
    // add and sub simply wrap
    always_comb begin
        case (exec.op)
            cdb_pkg::OP_ADD: alu_value = exec.src_a + exec.src_b;
            cdb_pkg::OP_SUB: alu_value = exec.src_a - exec.src_b;
            cdb_pkg::OP_AND: alu_value = exec.src_a & exec.src_b;
            cdb_pkg::OP_XOR: alu_value = exec.src_a ^ exec.src_b;
            default:         alu_value = '0;
        endcase
    end

    // tag rides along with the value
    always_comb begin
        stage_result.tag   = exec.tag;
        stage_result.value = alu_value;
    end

    // result lands in the queue on the edge after exec
    assign stage_valid = exec.valid;

    // queue controls
    assign push       = stage_valid;
    assign head_valid = (count != '0);
    // arbiter only pops a valid head
    assign do_pop     = pop && head_valid;

    // oldest entry faces the arbiter
    assign head = queue_mem[rd_ptr];

    // storage write
    // credits keep a push away from a full queue
    always_ff @(posedge clock) begin
        if (push) begin
            queue_mem[wr_ptr] <= stage_result;
        end
    end

    // pointers and occupancy
    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            // push and pop together leave count alone
            case ({push, do_pop})
                2'b10:   count <= count + cdb_pkg::credit_t'(1);
                2'b01:   count <= count - cdb_pkg::credit_t'(1);
                default: count <= count;
            endcase
        end
    end

endmodule

// File: src/cdb_arbiter.sv
`include "cdb_macros.svh"

module cdb_arbiter (
    input  logic                                    clock,
    input  logic                                    reset,
    input  cdb_pkg::fu_result_t [`CDB_NUM_FU-1:0]   head,
    input  logic                [`CDB_NUM_FU-1:0]   head_valid,
    output logic                [`CDB_NUM_FU-1:0]   pop,
    output logic                [`CDB_NUM_FU-1:0]   credit_return,
    output cdb_pkg::cdb_packet_t [`CDB_WIDTH-1:0]   cdb
);

    // one-hot slot choice per lane
    logic [`CDB_NUM_FU-1:0] lane_sel [`CDB_WIDTH];

    // heads not yet granted during the scan
    logic [`CDB_NUM_FU-1:0] remaining;

    // muxed head per lane
    cdb_pkg::fu_result_t lane_data [`CDB_WIDTH];
    logic [`CDB_WIDTH-1:0] lane_hit;

    // fixed priority scan
    // lane k takes the k-th lowest valid slot
    always_comb begin
        remaining = head_valid;
        pop       = '0;
        for (int k = 0; k < `CDB_WIDTH; k++) begin
            lane_sel[k] = '0;
            lane_hit[k] = 1'b0;
            for (int f = 0; f < `CDB_NUM_FU; f++) begin
                if (remaining[f] && !lane_hit[k]) begin
                    lane_sel[k][f] = 1'b1;
                    lane_hit[k]    = 1'b1;
                end
            end
            // granted slot drops out for higher lanes
            remaining = remaining & ~lane_sel[k];
            pop       = pop | lane_sel[k];
        end
    end

    // one-hot mux of the heads
    // empty lane yields zero
    always_comb begin
        for (int k = 0; k < `CDB_WIDTH; k++) begin
            lane_data[k] = '0;
            for (int f = 0; f < `CDB_NUM_FU; f++) begin
                if (lane_sel[k][f]) begin
                    lane_data[k] = lane_data[k] | head[f];
                end
            end
        end
    end

    // credit return trails pop by one edge
    always_ff @(posedge clock) begin
        if (reset) begin
            credit_return <= '0;
        end else begin
            credit_return <= pop;
        end
    end

    // bus lanes
    // lanes fill from 0 since the scan fills them in order
    always_ff @(posedge clock) begin
        for (int k = 0; k < `CDB_WIDTH; k++) begin
            if (reset) begin
                cdb[k].valid <= 1'b0;
            end else begin
                cdb[k].valid <= lane_hit[k];
                cdb[k].tag   <= lane_data[k].tag;
                cdb[k].value <= lane_data[k].value;
            end
        end
    end

endmodule

// File: src/cdb_top.sv
`include "cdb_macros.svh"

module cdb_top (
    input  logic                                          clock,
    input  logic                                          reset,
    input  cdb_pkg::issue_packet_t [`CDB_ISSUE_WIDTH-1:0] issue,
    output logic                   [`CDB_ISSUE_WIDTH-1:0] issue_ready,
    output cdb_pkg::cdb_packet_t   [`CDB_WIDTH-1:0]       cdb
);

    // dispatcher to slots
    cdb_pkg::exec_packet_t [`CDB_NUM_FU-1:0] exec;

    // slots to arbiter
    cdb_pkg::fu_result_t [`CDB_NUM_FU-1:0] head;
    logic                [`CDB_NUM_FU-1:0] head_valid;

    // arbiter back to slots and dispatcher
    logic [`CDB_NUM_FU-1:0] pop;
    logic [`CDB_NUM_FU-1:0] credit_return;

    // credit check and per slot exec register
    issue_dispatch dispatch0 (
        .clock         (clock),
        .reset         (reset),
        .issue         (issue),
        .issue_ready   (issue_ready),
        .credit_return (credit_return),
        .exec          (exec)
    );

    // identical execution slots
    for (genvar i = 0; i < `CDB_NUM_FU; i++) begin : g_slot
        fu_slot slot0 (
            .clock      (clock),
            .reset      (reset),
            .exec       (exec[i]),
            .pop        (pop[i]),
            .head       (head[i]),
            .head_valid (head_valid[i])
        );
    end

    // picks up to CDB_WIDTH heads per cycle
    cdb_arbiter arbiter0 (
        .clock         (clock),
        .reset         (reset),
        .head          (head),
        .head_valid    (head_valid),
        .pop           (pop),
        .credit_return (credit_return),
        .cdb           (cdb)
    );

endmodule

// File: sim/tb_cdb_model.svh
`ifndef TB_CDB_MODEL_SVH
`define TB_CDB_MODEL_SVH

// rows 0 and 1 hand made, burst rows on slot 0, random rows after
localparam int NUM_ROWS    = 16;
localparam int BURST_FIRST = 2;
localparam int BURST_LAST  = 5;
localparam int NUM_TAGS    = 1 << `CDB_TAG_WIDTH;
// lone issue of row 0, sent with the bus idle
localparam int LATENCY_TAG = 0;

// stimulus table, one packet per port per row
cdb_pkg::issue_packet_t stim_table [NUM_ROWS][`CDB_ISSUE_WIDTH];
int                     total_valid;

// scoreboard indexed by tag
cdb_pkg::data_t expected_by_tag [NUM_TAGS];
int             slot_by_tag [NUM_TAGS];
int             accept_time_by_tag [NUM_TAGS];
bit             pending_by_tag [NUM_TAGS];

// acceptance order per slot
int order_tags [`CDB_NUM_FU][NUM_TAGS];
int order_rd [`CDB_NUM_FU];
int order_wr [`CDB_NUM_FU];

logic [31:0] lfsr_state;

// fibonacci, taps 32 22 2 1
function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
endfunction

// one lfsr step per bit taken
function automatic logic [31:0] random_bits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
        value = {value[30:0], lfsr_bit()};
    end
    return value;
endfunction

// op rule, add and sub wrap at data width
function automatic cdb_pkg::data_t expected_result(input cdb_pkg::issue_packet_t pkt);
    case (pkt.op)
        cdb_pkg::OP_ADD: return pkt.src_a + pkt.src_b;
        cdb_pkg::OP_SUB: return pkt.src_a - pkt.src_b;
        cdb_pkg::OP_AND: return pkt.src_a & pkt.src_b;
        default:         return pkt.src_a ^ pkt.src_b;
    endcase
endfunction

function automatic cdb_pkg::issue_packet_t make_packet(
    input logic           valid,
    input logic [31:0]    fu,
    input logic [31:0]    op,
    input cdb_pkg::data_t src_a,
    input cdb_pkg::data_t src_b,
    input int             tag
);
    cdb_pkg::issue_packet_t pkt;
    pkt.valid = valid;
    pkt.fu    = cdb_pkg::fu_idx_t'(fu);
    pkt.op    = cdb_pkg::alu_op_e'(op[1:0]);
    pkt.src_a = src_a;
    pkt.src_b = src_b;
    pkt.tag   = cdb_pkg::tag_t'(tag);
    return pkt;
endfunction

task automatic build_stimulus();
    logic        valid;
    logic [31:0] fu;
    logic [31:0] op;
    logic [31:0] src_a;
    logic [31:0] src_b;
    lfsr_state  = 32'h11be_3cae;
    total_valid = 0;
    for (int r = 0; r < NUM_ROWS; r++) begin
        for (int p = 0; p < `CDB_ISSUE_WIDTH; p++) begin
            // draws kept in a fixed order
            valid = (random_bits(2) != 0);
            fu    = random_bits(`CDB_FU_IDX_WIDTH);
            op    = random_bits(2);
            src_a = random_bits(32);
            src_b = random_bits(32);
            // burst rows all hit slot 0
            if (r >= BURST_FIRST && r <= BURST_LAST) begin
                valid = 1'b1;
                fu    = 0;
            end
            stim_table[r][p] = make_packet(valid, fu, op, src_a, src_b,
                                           r * `CDB_ISSUE_WIDTH + p);
        end
    end
    // single add with wrap, bus idle
    stim_table[0][0] = make_packet(1, 1, cdb_pkg::OP_ADD, 32'hffff_fff0, 32'h0000_0025, 0);
    stim_table[0][1] = make_packet(0, 0, 0, 0, 0, 1);
    stim_table[0][2] = make_packet(0, 0, 0, 0, 0, 2);
    // ports 0 and 1 collide on slot 2
    stim_table[1][0] = make_packet(1, 2, cdb_pkg::OP_SUB, 32'd5, 32'd9, 3);
    stim_table[1][1] = make_packet(1, 2, cdb_pkg::OP_XOR, 32'h0f0f_00ff, 32'h00ff_0f0f, 4);
    stim_table[1][2] = make_packet(1, 3, cdb_pkg::OP_AND, 32'hdead_beef, 32'hffff_0000, 5);
    for (int r = 0; r < NUM_ROWS; r++) begin
        for (int p = 0; p < `CDB_ISSUE_WIDTH; p++) begin
            if (stim_table[r][p].valid) begin
                expected_by_tag[stim_table[r][p].tag] = expected_result(stim_table[r][p]);
                total_valid++;
            end
        end
    end
endtask

`endif

// File: sim/tb_cdb_top.sv
`include "cdb_macros.svh"

module tb_cdb_top;

    localparam int CLOCK_PERIOD = 100;
    localparam int DRIVE_DELAY  = 10;
    localparam int RESET_CYCLES = 3;

    logic                                          clock;
    logic                                          reset;
    cdb_pkg::issue_packet_t [`CDB_ISSUE_WIDTH-1:0] issue;
    logic                   [`CDB_ISSUE_WIDTH-1:0] issue_ready;
    cdb_pkg::cdb_packet_t   [`CDB_WIDTH-1:0]       cdb;

    // ports that transfer at the coming rising edge
    logic [`CDB_ISSUE_WIDTH-1:0] taken;
    // credits the dispatcher should hold this cycle
    int model_credits [`CDB_NUM_FU];
    int neg_count;
    int accept_count;
    int broadcast_count;
    // a valid port held back by credits alone
    bit stall_seen;

    `include "tb_cdb_model.svh"

    cdb_top dut0 (
        .clock       (clock),
        .reset       (reset),
        .issue       (issue),
        .issue_ready (issue_ready),
        .cdb         (cdb)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("ERROR: time %0t: %s, got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display("STATUS: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // each valid lane against the scoreboard
    task automatic check_lanes();
        int t;
        int slot;
        int prev_slot;
        prev_slot = -1;
        for (int k = 0; k < `CDB_WIDTH; k++) begin
            if (cdb[k].valid) begin
                t = cdb[k].tag;
                if (k > 0) begin
                    check_equal(cdb[k-1].valid, 1, "lane below is empty");
                end
                check_equal(pending_by_tag[t], 1, "broadcast tag not outstanding");
                slot = slot_by_tag[t];
                check_equal(slot > prev_slot, 1, "slot order across lanes");
                check_equal(order_tags[slot][order_rd[slot]], t, "order within slot");
                check_equal(cdb[k].value, expected_by_tag[t], "broadcast value");
                if (t == LATENCY_TAG) begin
                    check_equal(k, 0, "idle issue lane");
                    check_equal(neg_count - accept_time_by_tag[t], 3, "idle issue latency");
                end
                order_rd[slot]++;
                pending_by_tag[t] = 1'b0;
                // usable by the dispatcher from the next cycle
                model_credits[slot]++;
                broadcast_count++;
                prev_slot = slot;
            end
        end
    endtask

    task automatic record_accepts();
        int t;
        int slot;
        for (int p = 0; p < `CDB_ISSUE_WIDTH; p++) begin
            if (taken[p]) begin
                t    = issue[p].tag;
                slot = issue[p].fu;
                slot_by_tag[t]                   = slot;
                accept_time_by_tag[t]            = neg_count;
                pending_by_tag[t]                = 1'b1;
                order_tags[slot][order_wr[slot]] = t;
                order_wr[slot]++;
                model_credits[slot]--;
                accept_count++;
            end
        end
    endtask

    // sampled mid cycle, inputs and outputs settled
    task automatic observe_cycle();
        int lower;
        bit exp_ready;
        neg_count++;
        // one port per slot per cycle, lowest wins, needs a credit
        for (int p = 0; p < `CDB_ISSUE_WIDTH; p++) begin
            lower = 0;
            for (int q = 0; q < p; q++) begin
                if (issue[q].valid && (issue[q].fu == issue[p].fu)) begin
                    lower++;
                end
            end
            exp_ready = (lower == 0) && (model_credits[issue[p].fu] > 0);
            check_equal(issue_ready[p], exp_ready, "issue_ready");
            if (issue[p].valid && (lower == 0) && !exp_ready) begin
                stall_seen = 1'b1;
            end
            taken[p] = issue[p].valid && issue_ready[p];
        end
        check_lanes();
        record_accepts();
    endtask

    always @(negedge clock) begin
        if (reset) begin
            taken = '0;
        end else begin
            observe_cycle();
        end
    end

    initial begin
        logic [`CDB_ISSUE_WIDTH-1:0] pending;
        int                          row;
        reset           = 1'b1;
        issue           = '0;
        neg_count       = 0;
        accept_count    = 0;
        broadcast_count = 0;
        stall_seen      = 1'b0;
        for (int f = 0; f < `CDB_NUM_FU; f++) begin
            model_credits[f] = `CDB_QUEUE_DEPTH;
            order_rd[f]      = 0;
            order_wr[f]      = 0;
        end
        build_stimulus();
        repeat (RESET_CYCLES) @(posedge clock);
        #DRIVE_DELAY;
        reset = 1'b0;
        // one quiet cycle, idle bus and ready ports
        @(posedge clock);
        #DRIVE_DELAY;
        row = 0;
        while (row < NUM_ROWS) begin
            issue = '0;
            for (int p = 0; p < `CDB_ISSUE_WIDTH; p++) begin
                issue[p]   = stim_table[row][p];
                pending[p] = stim_table[row][p].valid;
            end
            // a port drops its packet only once taken
            while (pending != '0) begin
                @(posedge clock);
                #DRIVE_DELAY;
                for (int p = 0; p < `CDB_ISSUE_WIDTH; p++) begin
                    if (taken[p]) begin
                        pending[p]     = 1'b0;
                        issue[p].valid = 1'b0;
                    end
                end
            end
            row++;
        end
        while (broadcast_count != accept_count) begin
            @(posedge clock);
        end
        // stray lanes would show up here
        repeat (4) @(posedge clock);
        if ((accept_count == total_valid) && (broadcast_count == total_valid) && stall_seen) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("run incomplete: %0d of %0d tags issued, %0d broadcast, credit stall seen %0d",
                     accept_count, total_valid, broadcast_count, stall_seen);
            $display("STATUS: FAIL");
            $fatal(1, "incomplete run");
        end
    end

    // twenty cycles per row plus reset
    initial begin
        #((NUM_ROWS * 20 + RESET_CYCLES) * CLOCK_PERIOD);
        $display("timeout: the run did not finish, results still missing from the bus");
        $display("STATUS: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: vlog.f
+incdir+src
+incdir+sim
src/cdb_pkg.sv
src/issue_dispatch.sv
src/fu_slot.sv
src/cdb_arbiter.sv
src/cdb_top.sv
sim/tb_cdb_top.sv

// File: Bender.yml
package:
  name: cdb_writeback

export_include_dirs:
  - src

sources:
  - files:
      - src/cdb_pkg.sv
      - src/issue_dispatch.sv
      - src/fu_slot.sv
      - src/cdb_arbiter.sv
      - src/cdb_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_cdb_top.sv
